//--- hdl/rename_params.svh
//////////////////////////////////////////////////
// Size constants for the register-rename stage
// Include wherever a register, checkpoint or free
// list size is needed. Only NUM_CHECKPOINTS is
// meant to be tuned, and it must stay a power of 2
//////////////////////////////////////////////////

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural register file of RV32
`define NUM_ISA_REGS 32

// Physical register file shared by all renamed ops
`define NUM_PHYS_REGS 64

// Checkpoint slots, one is always the working copy
`define NUM_CHECKPOINTS 4

// Registers not held by the committed map
`define NUM_FREE_ENTRIES (`NUM_PHYS_REGS - `NUM_ISA_REGS)

`endif

//--- hdl/rename_pkg.sv
//////////////////////////////////////////////////
// Vector types shared by the rename stage
// Import with rename_pkg::* in the module header
//////////////////////////////////////////////////

`include "rename_params.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [$clog2(`NUM_ISA_REGS)-1:0] arch_reg_t;

    // Physical register index
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_reg_t;

    // Checkpoint slot label
    typedef logic [$clog2(`NUM_CHECKPOINTS)-1:0] chkpt_t;

    // Free register count, one bit over the pointer so a full list fits
    typedef logic [$clog2(`NUM_FREE_ENTRIES):0] free_cnt_t;

endpackage

//--- hdl/free_list.sv
//////////////////////////////////////////////////
// Checkpointed free list of physical registers
// Circular buffer with one shared tail and one
// head plus count per checkpoint slot. Reads pop
// from the working slot and frees append to all.
// Recover selects a saved head, rollback resets
// the head to the tail with a full count
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rename_params.svh"

module free_list import rename_pkg::*; (
    input  logic            clk_i,           // System clock
    input  logic            rstn_i,          // Async reset, active low
    input  logic            read_head_i,     // Pop request from rename
    input  logic [1:0]      add_free_i,      // Free valid per commit lane
    input  phys_reg_t [1:0] free_reg_i,      // Register freed per lane
    input  logic            do_chkpt_i,      // Checkpoint after this rename
    input  logic            recover_i,       // Restore a checkpoint
    input  chkpt_t          recover_chkpt_i, // Slot to restore
    input  logic            release_chkpt_i, // Drop the oldest checkpoint
    input  logic            rollback_i,      // Exception, back to committed state
    output phys_reg_t       new_reg_o,       // Allocated register, 0 if none
    output logic            rename_taken_o,  // Pop accepted this cycle
    output logic            chkpt_taken_o,   // Checkpoint accepted this cycle
    output chkpt_t          version_o,       // Working slot
    output chkpt_t          chkpt_o,         // Label of the last checkpoint
    output logic            out_of_chkpt_o,  // No slot left for a checkpoint
    output logic            empty_o          // Nothing to allocate
);

    localparam int PTR_W = $clog2(`NUM_FREE_ENTRIES);  // Buffer pointer width

    phys_reg_t                          fifo_mem [`NUM_FREE_ENTRIES];
    logic [PTR_W-1:0]                   head [`NUM_CHECKPOINTS];  // Pop pointer per slot
    free_cnt_t                          num_free [`NUM_CHECKPOINTS];
    logic [PTR_W-1:0]                   tail;           // Shared push pointer
    logic [PTR_W-1:0]                   tail_p1;
    logic [PTR_W-1:0]                   head_upd;       // Working head after this pop
    free_cnt_t                          num_cur;
    free_cnt_t                          num_upd;        // Working count after this cycle
    chkpt_t                             version_head;   // Working slot
    chkpt_t                             version_next;
    chkpt_t                             version_tail;   // Oldest live checkpoint
    chkpt_t                             version_tail_nxt;
    chkpt_t                             recover_dist;
    logic [$clog2(`NUM_CHECKPOINTS):0]  num_chkpt;      // Live checkpoints
    logic                               we0;
    logic                               we1;
    logic                               read_en;
    logic                               chkpt_en;

    // Register 0 never enters the list and nothing is freed on a rollback
    assign we0 = add_free_i[0] & (free_reg_i[0] != '0) & ~rollback_i;
    assign we1 = add_free_i[1] & (free_reg_i[1] != '0) & ~rollback_i;

    assign num_cur = num_free[version_head];
    assign empty_o = (num_cur == '0) & ~we0 & ~we1;  // A same-cycle free keeps it alive

    // Pop only when something is there and no recovery is running
    assign read_en  = read_head_i & ~empty_o & ~recover_i & ~rollback_i;
    // Checkpoint rides on a taken rename
    assign chkpt_en = do_chkpt_i & read_en & ~out_of_chkpt_o;

    assign tail_p1          = tail + 1'b1;
    assign head_upd         = head[version_head] + read_en;
    assign num_upd          = num_cur + we0 + we1 - read_en;
    assign version_next     = version_head + 1'b1;
    assign version_tail_nxt = version_tail + release_chkpt_i;
    assign recover_dist     = recover_chkpt_i - version_tail_nxt;  // Wraps mod slots

    //////////////////////////////////////////////////
    // Register storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NUM_FREE_ENTRIES; i++) begin
                fifo_mem[i] <= phys_reg_t'(`NUM_ISA_REGS + i);  // 32..63 in order
            end
        end else begin
            if (we0) fifo_mem[tail] <= free_reg_i[0];
            if (we1) fifo_mem[we0 ? tail_p1 : tail] <= free_reg_i[1];  // Packs behind lane 0
        end
    end

    //////////////////////////////////////////////////
    // Pointers, counts and checkpoint slots
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            version_head <= '0;
            version_tail <= '0;
            num_chkpt    <= '0;
            tail         <= '0;
            chkpt_o      <= '0;
            for (int i = 0; i < `NUM_CHECKPOINTS; i++) begin
                head[i]     <= '0;
                num_free[i] <= free_cnt_t'(`NUM_FREE_ENTRIES);
            end
        end else if (rollback_i) begin
            // Everything not in the committed map is free again
            version_head <= '0;
            version_tail <= '0;
            num_chkpt    <= '0;
            chkpt_o      <= '0;
            head[0]      <= tail;
            num_free[0]  <= free_cnt_t'(`NUM_FREE_ENTRIES);
        end else begin
            version_tail <= version_tail_nxt;
            tail         <= tail + we0 + we1;
            chkpt_o      <= version_head;  // Frozen slot after a checkpoint
            for (int i = 0; i < `NUM_CHECKPOINTS; i++) begin
                num_free[i] <= num_free[i] + we0 + we1;  // Frees reach every version
            end
            if (recover_i) begin
                version_head <= recover_chkpt_i;
                num_chkpt    <= {1'b0, recover_dist};
            end else begin
                num_chkpt              <= num_chkpt + chkpt_en - release_chkpt_i;
                head[version_head]     <= head_upd;   // Only the working slot pops
                num_free[version_head] <= num_upd;
                if (chkpt_en) begin
                    // Next slot continues from the state after this rename
                    version_head           <= version_next;
                    head[version_next]     <= head_upd;
                    num_free[version_next] <= num_upd;
                end
            end
        end
    end

    // Pass a same-cycle free straight through when the list is drained
    always_comb begin
        if (!read_en)                  new_reg_o = '0;
        else if ((num_cur == '0) & we0) new_reg_o = free_reg_i[0];
        else if ((num_cur == '0) & we1) new_reg_o = free_reg_i[1];
        else                           new_reg_o = fifo_mem[head[version_head]];
    end

    assign rename_taken_o = read_en;
    assign chkpt_taken_o  = chkpt_en;
    assign version_o      = version_head;
    assign out_of_chkpt_o = (num_chkpt == `NUM_CHECKPOINTS - 1);

    // Working count agrees with the ring distance from head to tail
    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (num_cur <= free_cnt_t'(`NUM_FREE_ENTRIES)) &&
        (PTR_W'(num_cur) == PTR_W'(tail - head[version_head])));

    // Live checkpoints match the slot distance and stay under the slot limit
    a_chkpt_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (num_chkpt <= `NUM_CHECKPOINTS - 1) &&
        (chkpt_t'(num_chkpt) == chkpt_t'(version_head - version_tail)));

endmodule

//--- hdl/rename_table.sv
//////////////////////////////////////////////////
// Checkpointed register map table
// One speculative map per checkpoint slot, read
// and written in the slot named by version_i.
// A committed map tracks retired mappings and is
// copied into slot 0 on an exception rollback
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rename_params.svh"

module rename_table import rename_pkg::*; (
    input  logic            clk_i,           // System clock
    input  logic            rstn_i,          // Async reset, active low
    input  arch_reg_t       src1_arch_i,     // First source
    input  arch_reg_t       src2_arch_i,     // Second source
    input  arch_reg_t       dst_arch_i,      // Destination
    input  logic            rename_taken_i,  // Write the destination mapping
    input  phys_reg_t       new_phys_i,      // New destination mapping
    input  logic            chkpt_taken_i,   // Copy into the next slot
    input  chkpt_t          version_i,       // Working slot from the free list
    input  logic            recover_i,       // Restore a checkpoint
    input  chkpt_t          recover_chkpt_i, // Slot being restored
    input  logic            rollback_i,      // Exception, back to committed map
    input  logic [1:0]      commit_valid_i,  // Commit valid per lane
    input  arch_reg_t [1:0] commit_arch_i,   // Retired destination
    input  phys_reg_t [1:0] commit_phys_i,   // Retired mapping
    output phys_reg_t       src1_phys_o,
    output phys_reg_t       src2_phys_o,
    output phys_reg_t       old_phys_o       // Mapping being replaced
);

    phys_reg_t  spec_map [`NUM_CHECKPOINTS][`NUM_ISA_REGS];  // Speculative maps
    phys_reg_t  commit_map [`NUM_ISA_REGS];                  // Retired state
    chkpt_t     version_next;
    logic       dst_wr;

    assign version_next = version_i + 1'b1;
    assign dst_wr       = rename_taken_i & (dst_arch_i != '0);  // x0 stays hardwired

    // Lookups see only what was written before this edge
    assign src1_phys_o = spec_map[version_i][src1_arch_i];
    assign src2_phys_o = spec_map[version_i][src2_arch_i];
    assign old_phys_o  = spec_map[version_i][dst_arch_i];

    //////////////////////////////////////////////////
    // Speculative maps
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                    spec_map[c][r] <= phys_reg_t'(r);  // Identity map
                end
            end
        end else if (rollback_i) begin
            for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                spec_map[0][r] <= commit_map[r];
            end
        end else begin
            if (dst_wr) spec_map[version_i][dst_arch_i] <= new_phys_i;
            // Next slot starts from the map including this rename
            if (chkpt_taken_i) begin
                for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                    spec_map[version_next][r] <=
                        (dst_wr && (dst_arch_i == arch_reg_t'(r))) ? new_phys_i
                                                                   : spec_map[version_i][r];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Committed map
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                commit_map[r] <= phys_reg_t'(r);
            end
        end else if (!rollback_i) begin  // Commits dropped with their frees
            for (int l = 0; l < 2; l++) begin
                // Lane 1 is younger and wins on the same register
                if (commit_valid_i[l] && (commit_arch_i[l] != '0)) begin
                    commit_map[commit_arch_i[l]] <= commit_phys_i[l];
                end
            end
        end
    end

    // x0 reads as p0 in every slot, across renames, checkpoints and rollbacks
    a_x0_is_p0: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (src1_arch_i == '0) |-> (src1_phys_o == '0));

    // The free list moves the working slot to the recovered label
    a_recover_slot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (recover_i && !rollback_i) |=> (version_i == $past(recover_chkpt_i)));

endmodule

//--- hdl/rename_unit.sv
//////////////////////////////////////////////////
// Register-rename stage top level
// One rename per cycle with two sources and one
// destination, two commit lanes, checkpoint,
// recover, release and exception rollback
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            rename_valid_i,    // Rename request
    input  arch_reg_t       src1_arch_i,
    input  arch_reg_t       src2_arch_i,
    input  arch_reg_t       dst_arch_i,
    input  logic            checkpoint_i,      // Branch, checkpoint after rename
    input  logic [1:0]      commit_valid_i,
    input  arch_reg_t [1:0] commit_arch_i,
    input  phys_reg_t [1:0] commit_phys_i,
    input  phys_reg_t [1:0] commit_old_phys_i, // Freed on commit
    input  logic            recover_i,         // Mispredict recovery
    input  chkpt_t          recover_chkpt_i,
    input  logic            release_chkpt_i,   // Oldest branch resolved
    input  logic            rollback_i,        // Exception
    output logic            rename_ready_o,
    output phys_reg_t       new_phys_o,
    output phys_reg_t       old_phys_o,
    output phys_reg_t       src1_phys_o,
    output phys_reg_t       src2_phys_o,
    output chkpt_t          chkpt_o,
    output out_of_chkpt_o
);

    logic   rename_taken;  // Free list popped, map writes
    logic   chkpt_taken;   // Map copies into next slot
    logic   fl_empty;
    chkpt_t version;       // Working slot

    assign rename_ready_o = ~fl_empty;

    free_list u_free_list (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .read_head_i     (rename_valid_i),
        .add_free_i      (commit_valid_i),
        .free_reg_i      (commit_old_phys_i),
        .do_chkpt_i      (checkpoint_i),
        .recover_i       (recover_i),
        .recover_chkpt_i (recover_chkpt_i),
        .release_chkpt_i (release_chkpt_i),
        .rollback_i      (rollback_i),
        .new_reg_o       (new_phys_o),
        .rename_taken_o  (rename_taken),
        .chkpt_taken_o   (chkpt_taken),
        .version_o       (version),
        .chkpt_o         (chkpt_o),
        .out_of_chkpt_o  (out_of_chkpt_o),
        .empty_o         (fl_empty)
    );

    rename_table u_rename_table (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .src1_arch_i     (src1_arch_i),
        .src2_arch_i     (src2_arch_i),
        .dst_arch_i      (dst_arch_i),
        .rename_taken_i  (rename_taken),
        .new_phys_i      (new_phys_o),
        .chkpt_taken_i   (chkpt_taken),
        .version_i       (version),
        .recover_i       (recover_i),
        .recover_chkpt_i (recover_chkpt_i),
        .rollback_i      (rollback_i),
        .commit_valid_i  (commit_valid_i),
        .commit_arch_i   (commit_arch_i),
        .commit_phys_i   (commit_phys_i),
        .src1_phys_o     (src1_phys_o),
        .src2_phys_o     (src2_phys_o),
        .old_phys_o      (old_phys_o)
    );

endmodule

//--- test/rename_unit_tb.sv
//////////////////////////////////////////////////
// Testbench for the register-rename stage
// LFSR-chosen registers drive renames, commits,
// checkpoints, recovers and a rollback. A model
// of the free list and maps checks every cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rename_params.svh"

module rename_unit_tb import rename_pkg::*; ();

    localparam int LEN_RESET  = 10;
    localparam int LEN_TESTS  = 34 + 7 + 13 + 3 + 34;            // Cycles of tests 1 to 5
    localparam int MAX_CYCLES = 2 * (LEN_RESET + LEN_TESTS);

    logic            clk_i = 1'b0;
    logic            rstn_i;
    logic            rename_valid_i, checkpoint_i, recover_i, release_chkpt_i, rollback_i;
    arch_reg_t       src1_arch_i, src2_arch_i, dst_arch_i;
    chkpt_t          recover_chkpt_i;
    logic [1:0]      commit_valid_i;
    arch_reg_t [1:0] commit_arch_i;
    phys_reg_t [1:0] commit_phys_i, commit_old_phys_i;
    logic            rename_ready_o, out_of_chkpt_o;
    phys_reg_t       new_phys_o, old_phys_o, src1_phys_o, src2_phys_o;
    chkpt_t          chkpt_o;

    // Reference model state
    phys_reg_t m_fifo [`NUM_FREE_ENTRIES];
    int        m_head [`NUM_CHECKPOINTS];               // Pop index per slot
    int        m_cnt  [`NUM_CHECKPOINTS];               // Free count per slot
    phys_reg_t m_map  [`NUM_CHECKPOINTS][`NUM_ISA_REGS];
    phys_reg_t m_cmap [`NUM_ISA_REGS];                  // Committed map
    int        m_tail, m_ver, m_oldest, m_live;
    chkpt_t    m_chkpt;
    logic      chkpt_due;                               // Label defined on the next cycle
    logic      e_ready, e_ooc;                          // Expected outputs
    phys_reg_t e_new, e_old, e_src1, e_src2;
    chkpt_t    e_chkpt;
    logic      e_chkpt_due;

    logic [31:0] lfsr = 32'h91d6;
    int          cycles, n_checks, n_errors, err_mark, n_tests, n_failed;
    chkpt_t      label;

    rename_unit dut_i (.*);

    always #10 clk_i = ~clk_i;

    // One Galois step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic void reset_model();
        for (int i = 0; i < `NUM_FREE_ENTRIES; i++) begin
            m_fifo[i] = phys_reg_t'(`NUM_ISA_REGS + i);     // 32..63 queued
        end
        for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
            m_head[c] = 0;
            m_cnt[c]  = `NUM_FREE_ENTRIES;
            for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                m_map[c][r] = phys_reg_t'(r);
                m_cmap[r]   = phys_reg_t'(r);
            end
        end
        m_tail    = 0;
        m_ver     = 0;
        m_oldest  = 0;
        m_live    = 0;
        m_chkpt   = '0;
        chkpt_due = 1'b1;                                   // Label is 0 out of reset
    endfunction

    // Expected outputs for this cycle and then the state after the edge
    function automatic void step_model();
        logic [1:0] fr;
        logic       take;
        logic       chk;
        int         cnt;
        int         nxt;
        fr[0]   = commit_valid_i[0] && (commit_old_phys_i[0] != '0) && !rollback_i;
        fr[1]   = commit_valid_i[1] && (commit_old_phys_i[1] != '0) && !rollback_i;
        cnt     = m_cnt[m_ver];
        e_ready = (cnt != 0) || (fr != 2'b00);
        take    = rename_valid_i && e_ready && !recover_i && !rollback_i;
        chk     = take && checkpoint_i && (m_live < `NUM_CHECKPOINTS - 1);
        if (!take) e_new = '0;
        else if (cnt != 0) e_new = m_fifo[m_head[m_ver]];
        else e_new = fr[0] ? commit_old_phys_i[0] : commit_old_phys_i[1];  // Bypass
        e_old       = m_map[m_ver][dst_arch_i];
        e_src1      = m_map[m_ver][src1_arch_i];
        e_src2      = m_map[m_ver][src2_arch_i];
        e_chkpt     = m_chkpt;
        e_chkpt_due = chkpt_due;
        e_ooc       = (m_live == `NUM_CHECKPOINTS - 1);
        chkpt_due   = 1'b0;
        if (rollback_i) begin
            m_ver     = 0;
            m_oldest  = 0;
            m_live    = 0;
            m_head[0] = m_tail;                             // Whole ring free again
            m_cnt[0]  = `NUM_FREE_ENTRIES;
            for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                m_map[0][r] = m_cmap[r];
            end
            return;
        end
        for (int l = 0; l < 2; l++) begin
            if (fr[l]) begin
                m_fifo[m_tail] = commit_old_phys_i[l];      // Every slot sees the push
                m_tail         = (m_tail + 1) % `NUM_FREE_ENTRIES;
                for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                    m_cnt[c]++;
                end
            end
            if (commit_valid_i[l] && (commit_arch_i[l] != '0)) begin
                m_cmap[commit_arch_i[l]] = commit_phys_i[l];
            end
        end
        m_oldest = (m_oldest + int'(release_chkpt_i)) % `NUM_CHECKPOINTS;
        if (recover_i) begin
            m_ver  = int'(recover_chkpt_i);
            m_live = (m_ver - m_oldest + `NUM_CHECKPOINTS) % `NUM_CHECKPOINTS;
            return;
        end
        m_live = m_live + int'(chk) - int'(release_chkpt_i);
        if (take) begin
            m_head[m_ver] = (m_head[m_ver] + 1) % `NUM_FREE_ENTRIES;
            m_cnt[m_ver]--;
            if (dst_arch_i != '0) m_map[m_ver][dst_arch_i] = e_new;
        end
        if (chk) begin
            nxt         = (m_ver + 1) % `NUM_CHECKPOINTS;   // Frozen slot stays at m_ver
            m_head[nxt] = m_head[m_ver];
            m_cnt[nxt]  = m_cnt[m_ver];
            for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                m_map[nxt][r] = m_map[m_ver][r];
            end
            m_chkpt   = chkpt_t'(m_ver);                    // Frozen slot is the label
            chkpt_due = 1'b1;
            m_ver     = nxt;
        end
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks and checker
    //////////////////////////////////////////////////

    task automatic check_phys(input string name, input phys_reg_t got, input phys_reg_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_chkpt(input string name, input chkpt_t got, input chkpt_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Outputs are settled half a period after the inputs change
    always @(negedge clk_i) begin
        if (rstn_i) begin
            step_model();
            check_flag("rename_ready_o", rename_ready_o, e_ready);
            check_phys("new_phys_o", new_phys_o, e_new);
            check_phys("old_phys_o", old_phys_o, e_old);
            check_phys("src1_phys_o", src1_phys_o, e_src1);
            check_phys("src2_phys_o", src2_phys_o, e_src2);
            if (e_chkpt_due) check_chkpt("chkpt_o", chkpt_o, e_chkpt);
            check_flag("out_of_chkpt_o", out_of_chkpt_o, e_ooc);
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // One cycle of inputs that returns at the falling edge
    task automatic drive_cycle(input logic ren, input logic chk, input logic [1:0] cv,
                               input phys_reg_t o0, input phys_reg_t o1, input logic rec,
                               input chkpt_t rc, input logic rel, input logic rb);
        @(posedge clk_i);
        rename_valid_i       <= ren;
        src1_arch_i          <= arch_reg_t'(rand_bits(5));
        src2_arch_i          <= arch_reg_t'(rand_bits(5));
        dst_arch_i           <= arch_reg_t'(rand_bits(5));
        checkpoint_i         <= chk;
        commit_valid_i       <= cv;
        commit_arch_i[0]     <= arch_reg_t'(rand_bits(5));
        commit_arch_i[1]     <= arch_reg_t'(rand_bits(5));
        commit_phys_i[0]     <= phys_reg_t'(rand_bits(6));
        commit_phys_i[1]     <= phys_reg_t'(rand_bits(6));
        commit_old_phys_i[0] <= o0;
        commit_old_phys_i[1] <= o1;
        recover_i            <= rec;
        recover_chkpt_i      <= rc;
        release_chkpt_i      <= rel;
        rollback_i           <= rb;
        @(negedge clk_i);
    endtask

    task automatic rename_op(input logic chk);
        drive_cycle(1'b1, chk, 2'b00, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic free_pair(input phys_reg_t o0, input phys_reg_t o1);
        drive_cycle(1'b0, 1'b0, 2'b11, o0, o1, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        #1;                                                 // Checker shares this edge
        n_tests++;
        if (n_errors == err_mark) begin
            $display("test %0d (%s) ok", n_tests, name);
        end else begin
            n_failed++;
            $display("test %0d (%s) failed, %0d errors", n_tests, name, n_errors - err_mark);
        end
        err_mark = n_errors;
    endtask

    initial begin
        {rename_valid_i, checkpoint_i, recover_i, release_chkpt_i, rollback_i} = '0;
        {src1_arch_i, src2_arch_i, dst_arch_i, recover_chkpt_i} = '0;
        {commit_valid_i, commit_arch_i, commit_phys_i, commit_old_phys_i} = '0;
        rstn_i = 1'b0;
        reset_model();
        repeat (LEN_RESET) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Fresh list hands out 32..63 and then stalls
        for (int i = 0; i < `NUM_FREE_ENTRIES; i++) begin
            rename_op(1'b0);
            check_phys("new_phys_o", new_phys_o, phys_reg_t'(`NUM_ISA_REGS + i));
        end
        rename_op(1'b0);
        check_flag("rename_ready_o", rename_ready_o, 1'b0);
        rename_op(1'b0);
        check_phys("new_phys_o", new_phys_o, '0);
        finish_test("allocate after reset");

        drive_cycle(1'b1, 1'b0, 2'b01, 6'd5, '0, 1'b0, '0, 1'b0, 1'b0);
        check_phys("new_phys_o", new_phys_o, 6'd5);         // Bypassed while empty
        free_pair(6'd0, 6'd7);                              // p0 never queued
        free_pair(6'd9, 6'd11);
        for (int i = 0; i < 3; i++) begin
            rename_op(1'b0);
            check_phys("new_phys_o", new_phys_o, phys_reg_t'(7 + 2 * i));
        end
        rename_op(1'b0);
        check_flag("rename_ready_o", rename_ready_o, 1'b0);
        finish_test("free and reuse");

        for (int i = 0; i < 4; i++) begin
            free_pair(phys_reg_t'(12 + 2 * i), phys_reg_t'(13 + 2 * i));
        end
        rename_op(1'b1);                                    // Branch takes p12
        rename_op(1'b0);
        label = chkpt_o;
        check_phys("new_phys_o", new_phys_o, 6'd13);        // First pop after the branch
        rename_op(1'b0);
        drive_cycle(1'b1, 1'b0, 2'b00, '0, '0, 1'b1, label, 1'b0, 1'b0);
        check_phys("new_phys_o", new_phys_o, '0);           // Recover blocks the rename
        rename_op(1'b0);
        check_phys("new_phys_o", new_phys_o, 6'd13);
        for (int i = 0; i < `NUM_CHECKPOINTS - 1; i++) begin
            rename_op(1'b1);
        end
        rename_op(1'b1);
        check_flag("out_of_chkpt_o", out_of_chkpt_o, 1'b1);
        finish_test("checkpoint and recover");

        drive_cycle(1'b0, 1'b0, 2'b00, '0, '0, 1'b0, '0, 1'b1, 1'b0);
        rename_op(1'b1);
        check_flag("out_of_chkpt_o", out_of_chkpt_o, 1'b0);
        drive_cycle(1'b0, 1'b0, 2'b00, '0, '0, 1'b0, '0, 1'b0, 1'b0);
        check_flag("out_of_chkpt_o", out_of_chkpt_o, 1'b1);  // Slot reused
        finish_test("release checkpoint");

        drive_cycle(1'b1, 1'b0, 2'b11, 6'd20, 6'd21, 1'b0, '0, 1'b0, 1'b1);
        check_phys("new_phys_o", new_phys_o, '0);
        for (int i = 0; i < `NUM_FREE_ENTRIES; i++) begin
            rename_op(1'b0);
            check_flag("rename_ready_o", rename_ready_o, 1'b1);
        end
        rename_op(1'b0);
        check_flag("rename_ready_o", rename_ready_o, 1'b0);
        finish_test("rollback");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/rename_unit.sv
test/rename_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := rename_unit_tb
FILELIST   := list.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
